// File: fc_accel.f
fc_pkg.sv
fc_mac_if.sv
fc_ctrl_fsm.sv
fc_counter.sv
fc_buffer.sv
fc_mac.sv
fc_post.sv
fc_top.sv
tb_fc_checker.sv
tb_fc.sv

// File: fc_buffer.sv
`timescale 1ns/1ps

module fc_buffer #(
  parameter int FEAT_DEPTH = 64,
  parameter int MAX_OUT    = 16
) (
  input  logic                         clk,
  input  logic [fc_pkg::DATA_W-1:0]     s_data,
  input  logic                         feat_we,
  input  logic                         bias_we,
  input  logic [$clog2(FEAT_DEPTH)-1:0] word_idx,
  input  logic [$clog2(MAX_OUT)-1:0]    neuron_idx,
  output logic [7:0]                   bias_byte,
  fc_mac_if.buffer                     mac_bus
);

  localparam int BIAS_WORDS = (MAX_OUT + fc_pkg::LANES - 1) / fc_pkg::LANES;
  localparam int BIAS_IW    = (BIAS_WORDS > 1) ? $clog2(BIAS_WORDS) : 1;
  localparam int LANE_IW    = $clog2(fc_pkg::LANES);

  logic [fc_pkg::DATA_W-1:0] feat_mem [FEAT_DEPTH];
  logic [fc_pkg::DATA_W-1:0] bias_mem [BIAS_WORDS];
  logic [BIAS_IW-1:0]        bias_sel;
  logic [LANE_IW-1:0]        lane_sel;
  logic [fc_pkg::DATA_W-1:0] bias_word;

  always_ff @(posedge clk) begin
    if (feat_we) begin
      feat_mem[word_idx] <= s_data;
    end
    if (bias_we) begin
      bias_mem[BIAS_IW'(word_idx)] <= s_data;
    end
  end

  // feature read follows the word index of the incoming weight
  assign mac_bus.feat_word = feat_mem[word_idx];

  // neuron k sits in lane k mod 4 of word k div 4
  assign bias_sel  = BIAS_IW'(neuron_idx >> LANE_IW);
  assign lane_sel  = neuron_idx[LANE_IW-1:0];
  assign bias_word = bias_mem[bias_sel];
  assign bias_byte = bias_word[8*lane_sel +: 8];

endmodule

// File: fc_cases.txt
// columns: feat_words n_out gap_flag stall_flag, hex, one test per line
// feat_words up to 0x20, n_out up to 0x10
01 01 0 0
04 03 0 0
08 10 0 0
02 05 1 0
10 04 0 1
03 10 1 1
20 02 1 1
01 10 0 1
05 07 1 0
0c 0b 1 1
06 08 0 0
02 0d 1 1

// File: fc_counter.sv
`timescale 1ns/1ps

module fc_counter #(
  parameter int FEAT_DEPTH = 64,
  parameter int MAX_OUT    = 16,
  parameter int MAC_LAT    = 3
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           start,
  input  logic [$clog2(FEAT_DEPTH+1)-1:0] feat_words,
  input  logic [$clog2(MAX_OUT+1)-1:0]    n_out,
  input  logic                           bias_phase,
  input  logic                           word_step,
  input  logic                           row_step,
  input  logic                           drain_run,
  output logic [$clog2(FEAT_DEPTH)-1:0]   word_idx,
  output logic [$clog2(MAX_OUT)-1:0]      neuron_idx,
  output logic                           word_last,
  output logic                           row_last,
  output logic                           drain_done
);

  localparam int FW_W = $clog2(FEAT_DEPTH + 1);
  localparam int NO_W = $clog2(MAX_OUT + 1);
  localparam int DR_W = $clog2(MAC_LAT + 1);

  logic [FW_W-1:0] feat_lim;
  logic [NO_W-1:0] n_lim;
  logic [NO_W-1:0] bias_lim;
  logic [FW_W-1:0] word_lim;
  logic [DR_W-1:0] drain_cnt;

  // packed bias words, rounded up to whole words
  assign bias_lim = NO_W'((n_lim + (fc_pkg::LANES - 1)) / fc_pkg::LANES);
  assign word_lim = bias_phase ? FW_W'(bias_lim) : feat_lim;

  assign word_last  = (FW_W'(word_idx) == (word_lim - FW_W'(1)));
  assign row_last   = (NO_W'(neuron_idx) == (n_lim - NO_W'(1)));
  assign drain_done = drain_run && (drain_cnt == DR_W'(MAC_LAT - 1));

  always_ff @(posedge clk) begin
    if (!rstn) begin
      feat_lim   <= '0;
      n_lim      <= '0;
      word_idx   <= '0;
      neuron_idx <= '0;
      drain_cnt  <= '0;
    end else begin
      if (start) begin
        feat_lim   <= feat_words;
        n_lim      <= n_out;
        word_idx   <= '0;
        neuron_idx <= '0;
      end else begin
        // wraps at the end of every load or row
        if (word_step) begin
          word_idx <= word_last ? '0 : word_idx + 1'b1;
        end
        if (row_step) begin
          neuron_idx <= row_last ? '0 : neuron_idx + 1'b1;
        end
      end
      if (drain_run) begin
        drain_cnt <= drain_done ? '0 : drain_cnt + 1'b1;
      end
    end
  end

  a_feat_lim: assert property (@(posedge clk) disable iff (!rstn)
    start |=> (feat_lim != '0) && (feat_lim <= FEAT_DEPTH));

  a_n_lim: assert property (@(posedge clk) disable iff (!rstn)
    start |=> (n_lim != '0) && (n_lim <= MAX_OUT));

endmodule

// File: fc_ctrl_fsm.sv
`timescale 1ns/1ps

module fc_ctrl_fsm (
  input  logic            clk,
  input  logic            rstn,
  input  fc_pkg::fc_cmd_e cmd,
  input  logic            start,
  input  logic            s_valid,
  input  logic            m_ready,
  input  logic            word_last,
  input  logic            row_last,
  input  logic            drain_done,
  output logic            s_ready,
  output logic            feat_we,
  output logic            bias_we,
  output logic            bias_phase,
  output logic            word_step,
  output logic            row_step,
  output logic            drain_run,
  output logic            post_load,
  output logic            emit,
  output logic            feat_loaded,
  output logic            bias_loaded,
  output logic            fc_done,
  fc_mac_if.ctrl          mac_bus
);

  fc_pkg::fc_state_e state;
  fc_pkg::fc_state_e state_nxt;
  logic              beat;
  logic              handshake;
  logic              first_pend;

  ////////////////////
  // state decodes
  ////////////////////

  assign s_ready = (state == fc_pkg::st_load_feat) ||
                   (state == fc_pkg::st_load_bias) ||
                   (state == fc_pkg::st_run_row);

  assign beat       = s_valid && s_ready;
  assign feat_we    = beat && (state == fc_pkg::st_load_feat);
  assign bias_we    = beat && (state == fc_pkg::st_load_bias);
  assign bias_phase = (state == fc_pkg::st_load_bias);
  assign word_step  = beat;
  assign drain_run  = (state == fc_pkg::st_drain);
  assign post_load  = (state == fc_pkg::st_post);
  assign emit       = (state == fc_pkg::st_emit);
  assign handshake  = emit && m_ready;
  assign row_step   = handshake;

  // weight beats go straight into the MAC
  assign mac_bus.beat_valid = beat && (state == fc_pkg::st_run_row);
  assign mac_bus.beat_first = mac_bus.beat_valid && first_pend;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      fc_pkg::st_idle: begin
        if (start) begin
          case (cmd)
            fc_pkg::cmd_load_feat: state_nxt = fc_pkg::st_load_feat;
            fc_pkg::cmd_load_bias: state_nxt = fc_pkg::st_load_bias;
            fc_pkg::cmd_run:       state_nxt = fc_pkg::st_run_row;
            default:               state_nxt = fc_pkg::st_idle;
          endcase
        end
      end
      fc_pkg::st_load_feat,
      fc_pkg::st_load_bias: begin
        if (beat && word_last) begin
          state_nxt = fc_pkg::st_idle;
        end
      end
      fc_pkg::st_run_row: begin
        if (beat && word_last) begin
          state_nxt = fc_pkg::st_drain;
        end
      end
      fc_pkg::st_drain: begin
        if (drain_done) begin
          state_nxt = fc_pkg::st_post;
        end
      end
      fc_pkg::st_post: state_nxt = fc_pkg::st_emit;
      fc_pkg::st_emit: begin
        if (handshake) begin
          state_nxt = row_last ? fc_pkg::st_idle : fc_pkg::st_run_row;
        end
      end
      default: state_nxt = fc_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state       <= fc_pkg::st_idle;
      first_pend  <= 1'b0;
      feat_loaded <= 1'b0;
      bias_loaded <= 1'b0;
      fc_done     <= 1'b0;
    end else begin
      state   <= state_nxt;
      fc_done <= handshake && row_last;
      if (feat_we && word_last) begin
        feat_loaded <= 1'b1;
      end
      if (bias_we && word_last) begin
        bias_loaded <= 1'b1;
      end
      // armed on every entry to a row, cleared by its first beat
      if ((state_nxt == fc_pkg::st_run_row) && (state != fc_pkg::st_run_row)) begin
        first_pend <= 1'b1;
      end else if (mac_bus.beat_valid) begin
        first_pend <= 1'b0;
      end
    end
  end

  // a new command would relatch the counter limits mid-operation
  a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
    start |-> (state == fc_pkg::st_idle));

endmodule

// File: fc_mac.sv
`timescale 1ns/1ps

module fc_mac (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic [fc_pkg::DATA_W-1:0] weight_word,
  fc_mac_if.mac                    mac_bus
);

  localparam int PROD_W = 16;
  localparam int SUM_W  = PROD_W + $clog2(fc_pkg::LANES);

  logic signed [PROD_W-1:0] prod [fc_pkg::LANES];
  logic signed [SUM_W-1:0]  sum_nxt;
  logic signed [SUM_W-1:0]  lane_sum;
  logic                     v1;
  logic                     v2;
  logic                     f1;
  logic                     f2;

  // valid bits ride along with each beat
  always_ff @(posedge clk) begin
    if (!rstn) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
    end else begin
      v1 <= mac_bus.beat_valid;
      v2 <= v1;
    end
  end

  ////////////////////
  // stage 1 products
  ////////////////////

  always_ff @(posedge clk) begin
    f1 <= mac_bus.beat_first;
    for (int l = 0; l < fc_pkg::LANES; l++) begin
      prod[l] <= $signed(mac_bus.feat_word[8*l +: 8]) * $signed(weight_word[8*l +: 8]);
    end
  end

  ////////////////////
  // stage 2 lane sum
  ////////////////////

  always_comb begin
    sum_nxt = '0;
    for (int l = 0; l < fc_pkg::LANES; l++) begin
      sum_nxt = sum_nxt + {{(SUM_W-PROD_W){prod[l][PROD_W-1]}}, prod[l]};
    end
  end

  always_ff @(posedge clk) begin
    f2       <= f1;
    lane_sum <= sum_nxt;
  end

  ////////////////////
  // stage 3 accumulate
  ////////////////////

  // first word of a row restarts the sum
  always_ff @(posedge clk) begin
    if (v2) begin
      if (f2) begin
        mac_bus.acc <= {{(fc_pkg::ACC_W-SUM_W){lane_sum[SUM_W-1]}}, lane_sum};
      end else begin
        mac_bus.acc <= mac_bus.acc + {{(fc_pkg::ACC_W-SUM_W){lane_sum[SUM_W-1]}}, lane_sum};
      end
    end
  end

endmodule

// File: fc_mac_if.sv
`timescale 1ns/1ps

interface fc_mac_if;

  // one accepted weight word and its row-start flag
  logic                            beat_valid;
  logic                            beat_first;

  // feature word paired with the weight word of the same beat
  logic [fc_pkg::DATA_W-1:0]       feat_word;

  // running dot product of the current row
  logic signed [fc_pkg::ACC_W-1:0] acc;

  modport ctrl (output beat_valid, output beat_first);

  modport buffer (output feat_word);

  modport mac (input beat_valid, input beat_first, input feat_word, output acc);

  modport post (input acc);

endinterface

// File: fc_pkg.sv
package fc_pkg;

  ////////////////////
  // datapath widths
  ////////////////////

  // stream word and lane split
  localparam int DATA_W    = 32;
  localparam int LANES     = 4;

  // signed accumulator for one dot product
  localparam int ACC_W     = 20;

  // quantize rule, accumulator carries six fractional bits
  localparam int FRAC_BITS = 6;
  localparam int SAT_MAX   = 127;

  ////////////////////
  // encodings
  ////////////////////

  typedef enum logic [2:0] {
    st_idle,
    st_load_feat,
    st_load_bias,
    st_run_row,
    st_drain,
    st_post,
    st_emit
  } fc_state_e;

  typedef enum logic [1:0] {
    cmd_none,
    cmd_load_feat,
    cmd_load_bias,
    cmd_run
  } fc_cmd_e;

endpackage

// File: fc_post.sv
`timescale 1ns/1ps

module fc_post #(
  parameter int MAX_OUT = 16
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      start,
  input  logic                      post_load,
  input  logic                      emit,
  input  logic                      m_ready,
  input  logic [7:0]                bias_byte,
  input  logic [$clog2(MAX_OUT)-1:0] neuron_idx,
  input  logic                      row_last,
  output logic                      m_valid,
  output logic [fc_pkg::DATA_W-1:0]  m_data,
  output logic                      m_last,
  output logic [$clog2(MAX_OUT)-1:0] max_idx,
  fc_mac_if.post                    mac_bus
);

  localparam int SUM_W = fc_pkg::ACC_W + 1;

  logic signed [SUM_W-1:0]           acc_ext;
  logic signed [SUM_W-1:0]           bias_scaled;
  logic signed [SUM_W-1:0]           biased;
  logic [SUM_W-fc_pkg::FRAC_BITS-1:0] scaled;
  logic [7:0]                        q_byte;
  logic [7:0]                        max_val;
  logic                              handshake;

  ////////////////////
  // bias add, quantize
  ////////////////////

  assign acc_ext     = {mac_bus.acc[fc_pkg::ACC_W-1], mac_bus.acc};
  assign bias_scaled = {{(SUM_W-8){bias_byte[7]}}, bias_byte} << fc_pkg::FRAC_BITS;
  assign biased      = acc_ext + bias_scaled;
  assign scaled      = biased[SUM_W-1:fc_pkg::FRAC_BITS];

  // relu, then clamp to the positive int8 range
  always_comb begin
    if (biased[SUM_W-1]) begin
      q_byte = '0;
    end else if (scaled > fc_pkg::SAT_MAX) begin
      q_byte = 8'(fc_pkg::SAT_MAX);
    end else begin
      q_byte = scaled[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (post_load) begin
      m_data <= {{(fc_pkg::DATA_W-8){1'b0}}, q_byte};
    end
  end

  assign m_valid   = emit;
  assign handshake = emit && m_ready;

  ////////////////////
  // last flag, argmax
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_last  <= 1'b0;
      max_val <= '0;
      max_idx <= '0;
    end else begin
      if (start) begin
        m_last  <= 1'b0;
        max_val <= '0;
      end else if (post_load) begin
        m_last <= row_last;
      end
      // ties keep the earlier neuron
      if (handshake && ((neuron_idx == '0) || (m_data[7:0] > max_val))) begin
        max_val <= m_data[7:0];
        max_idx <= neuron_idx;
      end
    end
  end

endmodule

// File: fc_top.sv
`timescale 1ns/1ps

module fc_top #(
  parameter int FEAT_DEPTH = 64,
  parameter int MAX_OUT    = 16,
  parameter int MAC_LAT    = 3
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  fc_pkg::fc_cmd_e                cmd,
  input  logic                           start,
  input  logic [$clog2(FEAT_DEPTH+1)-1:0] feat_words,
  input  logic [$clog2(MAX_OUT+1)-1:0]    n_out,
  input  logic                           s_valid,
  output logic                           s_ready,
  input  logic [fc_pkg::DATA_W-1:0]       s_data,
  output logic                           m_valid,
  input  logic                           m_ready,
  output logic [fc_pkg::DATA_W-1:0]       m_data,
  output logic                           m_last,
  output logic                           feat_loaded,
  output logic                           bias_loaded,
  output logic                           fc_done,
  output logic [$clog2(MAX_OUT)-1:0]      max_idx
);

  logic                         feat_we;
  logic                         bias_we;
  logic                         bias_phase;
  logic                         word_step;
  logic                         row_step;
  logic                         drain_run;
  logic                         post_load;
  logic                         emit;
  logic                         word_last;
  logic                         row_last;
  logic                         drain_done;
  logic [$clog2(FEAT_DEPTH)-1:0] word_idx;
  logic [$clog2(MAX_OUT)-1:0]    neuron_idx;
  logic [7:0]                   bias_byte;

  fc_mac_if mac_bus ();

  fc_ctrl_fsm u_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .cmd         (cmd),
    .start       (start),
    .s_valid     (s_valid),
    .m_ready     (m_ready),
    .word_last   (word_last),
    .row_last    (row_last),
    .drain_done  (drain_done),
    .s_ready     (s_ready),
    .feat_we     (feat_we),
    .bias_we     (bias_we),
    .bias_phase  (bias_phase),
    .word_step   (word_step),
    .row_step    (row_step),
    .drain_run   (drain_run),
    .post_load   (post_load),
    .emit        (emit),
    .feat_loaded (feat_loaded),
    .bias_loaded (bias_loaded),
    .fc_done     (fc_done),
    .mac_bus     (mac_bus.ctrl)
  );

  fc_counter #(
    .FEAT_DEPTH (FEAT_DEPTH),
    .MAX_OUT    (MAX_OUT),
    .MAC_LAT    (MAC_LAT)
  ) u_counter (
    .clk        (clk),
    .rstn       (rstn),
    .start      (start),
    .feat_words (feat_words),
    .n_out      (n_out),
    .bias_phase (bias_phase),
    .word_step  (word_step),
    .row_step   (row_step),
    .drain_run  (drain_run),
    .word_idx   (word_idx),
    .neuron_idx (neuron_idx),
    .word_last  (word_last),
    .row_last   (row_last),
    .drain_done (drain_done)
  );

  fc_buffer #(
    .FEAT_DEPTH (FEAT_DEPTH),
    .MAX_OUT    (MAX_OUT)
  ) u_buffer (
    .clk        (clk),
    .s_data     (s_data),
    .feat_we    (feat_we),
    .bias_we    (bias_we),
    .word_idx   (word_idx),
    .neuron_idx (neuron_idx),
    .bias_byte  (bias_byte),
    .mac_bus    (mac_bus.buffer)
  );

  // weights are consumed straight off the input stream
  fc_mac u_mac (
    .clk         (clk),
    .rstn        (rstn),
    .weight_word (s_data),
    .mac_bus     (mac_bus.mac)
  );

  fc_post #(
    .MAX_OUT (MAX_OUT)
  ) u_post (
    .clk        (clk),
    .rstn       (rstn),
    .start      (start),
    .post_load  (post_load),
    .emit       (emit),
    .m_ready    (m_ready),
    .bias_byte  (bias_byte),
    .neuron_idx (neuron_idx),
    .row_last   (row_last),
    .m_valid    (m_valid),
    .m_data     (m_data),
    .m_last     (m_last),
    .max_idx    (max_idx),
    .mac_bus    (mac_bus.post)
  );

endmodule

// File: tb_fc.sv
`timescale 1ns/1ps

module tb_fc;

  localparam int FEAT_DEPTH = 64;
  localparam int MAX_OUT    = 16;
  localparam int MAC_LAT    = 3;
  localparam int MAX_CASES  = 32;
  localparam int FW_W       = $clog2(FEAT_DEPTH + 1);
  localparam int NO_W       = $clog2(MAX_OUT + 1);

  logic                       clk;
  logic                       rstn;
  fc_pkg::fc_cmd_e            cmd;
  logic                       start;
  logic [FW_W-1:0]            feat_words;
  logic [NO_W-1:0]            n_out;
  logic                       s_valid;
  logic                       s_ready;
  logic [fc_pkg::DATA_W-1:0]  s_data;
  logic                       m_valid;
  logic                       m_ready;
  logic [fc_pkg::DATA_W-1:0]  m_data;
  logic                       m_last;
  logic                       feat_loaded;
  logic                       bias_loaded;
  logic                       fc_done;
  logic [$clog2(MAX_OUT)-1:0] max_idx;

  logic [7:0]  case_mem [4*MAX_CASES];
  logic [31:0] feat_arr [FEAT_DEPTH];
  logic [31:0] bias_arr [(MAX_OUT + 3) / 4];
  logic [31:0] wt_arr   [FEAT_DEPTH*MAX_OUT];
  logic [31:0] tx_arr   [FEAT_DEPTH*MAX_OUT];
  integer      seed;
  int          n_cases;
  int          cycle_cnt;
  int          cycle_limit = 0;

  fc_top #(
    .FEAT_DEPTH (FEAT_DEPTH),
    .MAX_OUT    (MAX_OUT),
    .MAC_LAT    (MAC_LAT)
  ) dut0 (
    .clk         (clk),
    .rstn        (rstn),
    .cmd         (cmd),
    .start       (start),
    .feat_words  (feat_words),
    .n_out       (n_out),
    .s_valid     (s_valid),
    .s_ready     (s_ready),
    .s_data      (s_data),
    .m_valid     (m_valid),
    .m_ready     (m_ready),
    .m_data      (m_data),
    .m_last      (m_last),
    .feat_loaded (feat_loaded),
    .bias_loaded (bias_loaded),
    .fc_done     (fc_done),
    .max_idx     (max_idx)
  );

  tb_fc_checker #(
    .MAX_OUT (MAX_OUT)
  ) chk0 (
    .clk         (clk),
    .rstn        (rstn),
    .s_valid     (s_valid),
    .s_ready     (s_ready),
    .m_valid     (m_valid),
    .m_ready     (m_ready),
    .m_data      (m_data),
    .m_last      (m_last),
    .fc_done     (fc_done),
    .max_idx     (max_idx),
    .feat_loaded (feat_loaded),
    .bias_loaded (bias_loaded)
  );

  always #10 clk = ~clk;

  ////////////////////
  // reference model
  ////////////////////

  function automatic int lane_value(input logic [31:0] w, input int l);
    logic signed [7:0] b;
    b = w[8*l +: 8];
    return int'(b);
  endfunction

  // scaled bias add, relu, clamp
  function automatic int quantize(input int dot, input int bias);
    int sum;
    sum = dot + (bias <<< fc_pkg::FRAC_BITS);
    if (sum < 0) begin
      sum = 0;
    end else begin
      sum = sum >>> fc_pkg::FRAC_BITS;
      if (sum > fc_pkg::SAT_MAX) begin
        sum = fc_pkg::SAT_MAX;
      end
    end
    return sum;
  endfunction

  // small weights keep some outputs inside the unclamped range
  function automatic logic [31:0] shrink_weight(input logic [31:0] w);
    logic [31:0] s;
    for (int l = 0; l < 4; l++) begin
      s[8*l +: 8] = {{4{w[8*l+3]}}, w[8*l +: 4]};
    end
    return s;
  endfunction

  ////////////////////
  // stimulus
  ////////////////////

  task automatic issue_cmd(input fc_pkg::fc_cmd_e op, input int fw, input int no);
    cmd        = op;
    start      = 1'b1;
    feat_words = fw[FW_W-1:0];
    n_out      = no[NO_W-1:0];
    @(posedge clk);
    #2;
    start = 1'b0;
    cmd   = fc_pkg::cmd_none;
  endtask

  // sends tx_arr[0..n-1], optionally until fc_done as well
  task automatic stream_words(input int n, input bit gaps, input bit stalls,
                              input bit wait_done);
    int          sent;
    bit          done_seen;
    bit          take;
    logic [31:0] r;
    sent      = 0;
    done_seen = 1'b0;
    while ((sent < n) || (wait_done && !done_seen)) begin
      s_valid = 1'b0;
      if (sent < n) begin
        r       = $random(seed);
        s_valid = !(gaps && (r[1:0] == 2'b00));
        s_data  = tx_arr[sent];
      end
      m_ready = 1'b1;
      if (stalls) begin
        r       = $random(seed);
        m_ready = r[0];
      end
      @(negedge clk);
      take      = s_valid && s_ready;
      done_seen = done_seen || fc_done;
      @(posedge clk);
      #2;
      if (take) begin
        sent++;
      end
    end
    s_valid = 1'b0;
  endtask

  task automatic run_case(input int id, input int fw, input int no, input bit gaps,
                          input bit stalls);
    int exp_bytes [MAX_OUT];
    int dot;
    int best;
    int best_idx;
    int nb;
    nb       = (no + 3) / 4;
    best     = -1;
    best_idx = 0;
    for (int j = 0; j < fw; j++) begin
      feat_arr[j] = $random(seed);
    end
    for (int j = 0; j < nb; j++) begin
      bias_arr[j] = $random(seed);
    end
    for (int k = 0; k < no; k++) begin
      for (int j = 0; j < fw; j++) begin
        wt_arr[k*fw + j] = $random(seed);
        if ((k % 2) == 0) begin
          wt_arr[k*fw + j] = shrink_weight(wt_arr[k*fw + j]);
        end
      end
    end
    // expected bytes and first index of the largest
    for (int k = 0; k < no; k++) begin
      dot = 0;
      for (int j = 0; j < fw; j++) begin
        for (int l = 0; l < fc_pkg::LANES; l++) begin
          dot += lane_value(feat_arr[j], l) * lane_value(wt_arr[k*fw + j], l);
        end
      end
      exp_bytes[k] = quantize(dot, lane_value(bias_arr[k/4], k % 4));
      if (exp_bytes[k] > best) begin
        best     = exp_bytes[k];
        best_idx = k;
      end
    end
    chk0.begin_test(id, no, best_idx);
    for (int k = 0; k < no; k++) begin
      chk0.push_byte(exp_bytes[k]);
    end

    for (int j = 0; j < fw; j++) begin
      tx_arr[j] = feat_arr[j];
    end
    issue_cmd(fc_pkg::cmd_load_feat, fw, no);
    stream_words(fw, gaps, 1'b0, 1'b0);
    chk0.check_load(1'b0);

    for (int j = 0; j < nb; j++) begin
      tx_arr[j] = bias_arr[j];
    end
    issue_cmd(fc_pkg::cmd_load_bias, fw, no);
    stream_words(nb, gaps, 1'b0, 1'b0);
    chk0.check_load(1'b1);

    for (int j = 0; j < no*fw; j++) begin
      tx_arr[j] = wt_arr[j];
    end
    issue_cmd(fc_pkg::cmd_run, fw, no);
    stream_words(no*fw, gaps, stalls, 1'b1);
  endtask

  // cycle budget scales with the cases in the file
  initial begin : watchdog
    cycle_cnt = 0;
    @(posedge clk);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main
    int fw;
    int no;
    clk        = 1'b0;
    rstn       = 1'b0;
    cmd        = fc_pkg::cmd_none;
    start      = 1'b0;
    feat_words = '0;
    n_out      = '0;
    s_valid    = 1'b0;
    s_data     = '0;
    m_ready    = 1'b0;
    seed       = 32'h7a40a8ea;
    for (int i = 0; i < 4*MAX_CASES; i++) begin
      case_mem[i] = '0;
    end
    $readmemh("fc_cases.txt", case_mem);
    n_cases     = 0;
    cycle_limit = 100;
    while ((n_cases < MAX_CASES) && (case_mem[4*n_cases] != 0)) begin
      fw = case_mem[4*n_cases];
      no = case_mem[4*n_cases + 1];
      cycle_limit += 4 * (fw + (no + 3) / 4 + no * (fw + MAC_LAT + 4) + 10);
      n_cases++;
    end

    repeat (10) @(posedge clk);
    #2;
    rstn = 1'b1;
    @(posedge clk);
    #2;

    for (int t = 0; t < n_cases; t++) begin
      run_case(t, case_mem[4*t], case_mem[4*t + 1], case_mem[4*t + 2][0],
               case_mem[4*t + 3][0]);
    end

    repeat (2) @(posedge clk);
    chk0.report_totals();
    if ((chk0.err_cnt == 0) && (chk0.tests_done == n_cases) && (n_cases > 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: tb_fc_checker.sv
`timescale 1ns/1ps

module tb_fc_checker #(
  parameter int MAX_OUT = 16
) (
  input logic                       clk,
  input logic                       rstn,
  input logic                       s_valid,
  input logic                       s_ready,
  input logic                       m_valid,
  input logic                       m_ready,
  input logic [fc_pkg::DATA_W-1:0]  m_data,
  input logic                       m_last,
  input logic                       fc_done,
  input logic [$clog2(MAX_OUT)-1:0] max_idx,
  input logic                       feat_loaded,
  input logic                       bias_loaded
);

  int                        exp_q [$];
  int                        err_cnt = 0;
  int                        tests_done = 0;
  int                        tests_failed = 0;
  int                        test_id;
  int                        n_exp;
  int                        max_exp;
  int                        beat_cnt;
  int                        err_base;
  bit                        test_open = 1'b0;
  logic                      hold_prev;
  logic [fc_pkg::DATA_W-1:0] data_prev;
  logic                      last_prev;
  logic                      final_prev;

  ////////////////////
  // calls from the testbench top
  ////////////////////

  task automatic begin_test(input int id, input int n, input int best);
    test_id   = id;
    n_exp     = n;
    max_exp   = best;
    beat_cnt  = 0;
    err_base  = err_cnt;
    exp_q.delete();
    test_open = 1'b1;
  endtask

  task automatic push_byte(input int b);
    exp_q.push_back(b);
  endtask

  // flags right after a load has taken its last word
  task automatic check_load(input bit is_bias);
    if (is_bias && !bias_loaded) begin
      $display("Error %0t ns: test %0d, bias_loaded low after the bias load", $time, test_id);
      err_cnt++;
    end
    if (!is_bias && !feat_loaded) begin
      $display("Error %0t ns: test %0d, feat_loaded low after the feature load", $time,
               test_id);
      err_cnt++;
    end
    if (s_ready) begin
      $display("Error %0t ns: test %0d, s_ready still high after a load", $time, test_id);
      err_cnt++;
    end
  endtask

  task automatic report_totals();
    $display("summary: %0d tests, %0d failed, %0d errors", tests_done, tests_failed, err_cnt);
  endtask

  ////////////////////
  // output stream monitor
  ////////////////////

  task automatic compare_beat();
    int                        exp_b;
    logic [fc_pkg::DATA_W-1:0] exp_word;
    logic                      last_exp;
    if (!test_open || (exp_q.size() == 0)) begin
      $display("Unexpected output beat at %0t ns, no result was pending", $time);
      err_cnt++;
    end else begin
      exp_b    = exp_q.pop_front();
      exp_word = exp_b;
      last_exp = (beat_cnt == n_exp - 1);
      if (m_data !== exp_word) begin
        $display("Error %0t ns: test %0d beat %0d, m_data %0h, expected %0h", $time,
                 test_id, beat_cnt, m_data, exp_word);
        err_cnt++;
      end
      if (m_last !== last_exp) begin
        $display("Error %0t ns: test %0d beat %0d, m_last %b, expected %b", $time,
                 test_id, beat_cnt, m_last, last_exp);
        err_cnt++;
      end
      beat_cnt++;
    end
  endtask

  task automatic close_test();
    if (beat_cnt != n_exp) begin
      $display("Test %0d ended after %0d output beats instead of %0d", test_id, beat_cnt,
               n_exp);
      err_cnt++;
    end
    if (max_idx != max_exp) begin
      $display("Error %0t ns: test %0d, max_idx %0d, expected %0d", $time, test_id,
               max_idx, max_exp);
      err_cnt++;
    end
    if (err_cnt != err_base) begin
      tests_failed++;
    end
    tests_done++;
    test_open = 1'b0;
    $display("test %0d done: %0d beats, max_idx %0d, %s", test_id, beat_cnt, max_idx,
             (err_cnt == err_base) ? "ok" : "failed");
  endtask

  // mid-cycle sampling, all DUT outputs are settled here
  always @(negedge clk) begin : sample
    if (!rstn) begin
      hold_prev  = 1'b0;
      final_prev = 1'b0;
    end else begin
      if (m_valid && s_valid && s_ready) begin
        $display("Input beat accepted at %0t ns while a result was waiting", $time);
        err_cnt++;
      end
      if (hold_prev) begin
        if (!m_valid) begin
          $display("m_valid dropped at %0t ns before the handshake", $time);
          err_cnt++;
        end else if ((m_data !== data_prev) || (m_last !== last_prev)) begin
          $display("Error %0t ns: output changed during a stall, %0h/%b, was %0h/%b", $time,
                   m_data, m_last, data_prev, last_prev);
          err_cnt++;
        end
      end
      // fc_done follows the final handshake by one cycle
      if (fc_done && !final_prev) begin
        $display("fc_done pulsed at %0t ns without a final handshake before it", $time);
        err_cnt++;
      end
      if (!fc_done && final_prev) begin
        $display("fc_done missing at %0t ns after the final handshake", $time);
        err_cnt++;
      end
      if (m_valid && m_ready) begin
        compare_beat();
      end
      if (fc_done && test_open) begin
        close_test();
      end
      hold_prev  = m_valid && !m_ready;
      data_prev  = m_data;
      last_prev  = m_last;
      final_prev = m_valid && m_ready && m_last;
    end
  end

endmodule
